//--- tb.f
common/ekf_buf_pkg.sv
logic/lane_ram.sv
map/map_sequencer.sv
map/dina_map.sv
logic/ekf_buf_top.sv
tb/tb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, exit status reports pass or fail
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -j 0 --top-module tb_top -f tb.f -o tb_sim &&
  ./obj_dir/tb_sim ||
  exit 1

//--- tb/tb_top.sv
module tb_top
  import ekf_buf_pkg::*;
();

  localparam int RST_CYC = 10;
  // Nine operations of up to 8 steps, coefficient load and read-back, with wide margin
  localparam int TIMEOUT_CYC = 2000;

  logic              clk;
  logic              sys_rst;
  map_cmd_t          cmd;
  logic              cmd_valid;
  logic              cmd_ready;
  logic              cb_wr_en;
  logic [ADDR_W-1:0] cb_wr_addr;
  lane_vec_t         cb_wr_data;
  lane_word_t        vt_1;
  lane_word_t        vt_2;
  logic              rd_en;
  logic [ADDR_W-1:0] rd_addr;
  lane_vec_t         rd_data;
  logic              rd_data_valid;
  logic              op_done;

  int                seed;
  int                cyc = 0;
  // Testbench copies of both memories
  lane_vec_t         cb_copy [1 << ADDR_W];
  lane_vec_t         exp_tb [1 << ADDR_W];
  lane_vec_t         exp_rd_q;
  logic [ADDR_W-1:0] rd_addr_q;
  logic              busy_q;

  ekf_buf_top dut_i (
    .clk           (clk),
    .sys_rst       (sys_rst),
    .cmd           (cmd),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .cb_wr_en      (cb_wr_en),
    .cb_wr_addr    (cb_wr_addr),
    .cb_wr_data    (cb_wr_data),
    .vt_1          (vt_1),
    .vt_2          (vt_2),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .op_done       (op_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_failure(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc == TIMEOUT_CYC) begin
      report_failure("timeout: the run did not finish within the cycle limit");
    end
  end

  // Expected row for the read issued one cycle earlier
  always @(posedge clk) begin
    exp_rd_q  <= exp_tb[rd_addr];
    rd_addr_q <= rd_addr;
  end

  // Busy from command transfer until its op_done
  always @(posedge clk) begin
    if (sys_rst) begin
      busy_q <= 1'b0;
    end else if (cmd_valid && cmd_ready) begin
      busy_q <= 1'b1;
    end else if (op_done) begin
      busy_q <= 1'b0;
    end
  end

  a_rd_row: assert property (
    @(posedge clk) disable iff (sys_rst)
    rd_en |=> rd_data_valid && (rd_data == exp_rd_q)
  ) else report_failure($sformatf("FAILED t=%0t row %0d read %h expected %h",
                                  $time, rd_addr_q, rd_data, exp_rd_q));

  // A held command must wait while an operation runs
  a_no_accept_busy: assert property (
    @(posedge clk) disable iff (sys_rst)
    busy_q |-> !cmd_ready
  ) else report_failure("cmd_ready went high while an operation was still running");

  a_done_owned: assert property (
    @(posedge clk) disable iff (sys_rst)
    op_done |-> busy_q
  ) else report_failure("op_done pulsed without an accepted command");

  // Mapping rules applied to one coefficient row
  function automatic lane_vec_t expect_row(input logic [SEL_W-1:0] sel, input logic l_k_0,
                                           input int seq, input lane_vec_t src_row,
                                           input lane_word_t v1, input lane_word_t v2);
    lane_vec_t r;
    r = '0;
    if (sel[SEL_W-1:2] == SRC_CB) begin
      if (sel[1:0] == DIR_POS) begin
        r = src_row;
      end else if (sel[1:0] == DIR_NEG) begin
        r[0] = src_row[3];
        r[1] = src_row[2];
        r[2] = src_row[1];
        r[3] = src_row[0];
      end else if (sel[1:0] == DIR_NEW && l_k_0) begin
        r[0] = src_row[0];
        r[1] = src_row[1];
      end else if (sel[1:0] == DIR_NEW) begin
        r[2] = src_row[0];
        r[3] = src_row[1];
      end
    end else if (sel[SEL_W-1:2] == SRC_NL_UPD) begin
      // Only the first two steps carry an update
      if (seq == 1) begin
        r[0] = v1;
      end else if (seq == 2) begin
        r[0] = v2;
      end
    end
    return r;
  endfunction

  function automatic map_cmd_t make_cmd(input logic [SEL_W-1:0] sel, input logic l_k_0,
                                        input int cb_base, input int tb_base, input int len);
    map_cmd_t c;
    c.sel     = sel;
    c.l_k_0   = l_k_0;
    c.cb_base = ADDR_W'(cb_base);
    c.tb_base = ADDR_W'(tb_base);
    c.len     = LEN_W'(len);
    return c;
  endfunction

  task automatic load_coeffs();
    for (int a = 0; a < (1 << ADDR_W); a++) begin
      @(negedge clk);
      for (int l = 0; l < LANES; l++) begin
        cb_copy[a][l] = $random(seed);
      end
      cb_wr_en   = 1'b1;
      cb_wr_addr = ADDR_W'(a);
      cb_wr_data = cb_copy[a];
    end
    @(negedge clk);
    cb_wr_en = 1'b0;
  endtask

  // Expected temporary rows once an operation has finished
  task automatic record_op(input map_cmd_t c);
    logic [ADDR_W-1:0] tb_a;
    logic [ADDR_W-1:0] cb_a;
    for (int k = 0; k < int'(c.len); k++) begin
      tb_a = c.tb_base + ADDR_W'(k);
      cb_a = c.cb_base + ADDR_W'(k);
      exp_tb[tb_a] = expect_row(c.sel, c.l_k_0, k + 1, cb_copy[cb_a], vt_1, vt_2);
    end
  endtask

  task automatic check_latency(input int cnt, input map_cmd_t c);
    assert (cnt == int'(c.len) + 3)
    else report_failure($sformatf("FAILED t=%0t op_done after %0d cycles, expected %0d",
                                  $time, cnt, int'(c.len) + 3));
  endtask

  task automatic issue_cmd(input map_cmd_t c);
    @(negedge clk);
    while (!cmd_ready) begin
      @(negedge clk);
    end
    cmd       = c;
    cmd_valid = 1'b1;
  endtask

  // Latency runs from the transfer cycle through the op_done cycle
  task automatic finish_cmd(input map_cmd_t c);
    int cnt;
    cnt = 1;
    @(negedge clk);
    cnt++;
    cmd_valid = 1'b0;
    while (!op_done) begin
      @(negedge clk);
      cnt++;
    end
    check_latency(cnt, c);
    record_op(c);
  endtask

  task automatic read_rows(input logic [ADDR_W-1:0] base, input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      rd_en   = 1'b1;
      rd_addr = base + ADDR_W'(i);
    end
    @(negedge clk);
    rd_en = 1'b0;
    // Let the last read be checked
    @(negedge clk);
  endtask

  task automatic run_op(input map_cmd_t c);
    issue_cmd(c);
    finish_cmd(c);
    read_rows(c.tb_base, int'(c.len));
  endtask

  // Second command stays valid through the whole first operation
  task automatic run_held_pair(input map_cmd_t a, input map_cmd_t b);
    int cnt;
    issue_cmd(a);
    cnt = 1;
    @(negedge clk);
    cnt++;
    cmd = b;
    while (!op_done) begin
      @(negedge clk);
      cnt++;
    end
    check_latency(cnt, a);
    record_op(a);
    // Port reopens one cycle after op_done
    @(negedge clk);
    assert (cmd_ready)
    else report_failure("held command was not released in the cycle after op_done");
    finish_cmd(b);
    read_rows(a.tb_base, int'(a.len));
    read_rows(b.tb_base, int'(b.len));
  endtask

  initial begin
    seed       = 39747;
    sys_rst    = 1'b1;
    cmd        = '0;
    cmd_valid  = 1'b0;
    cb_wr_en   = 1'b0;
    cb_wr_addr = '0;
    cb_wr_data = '0;
    rd_en      = 1'b0;
    rd_addr    = '0;
    vt_1       = $random(seed);
    vt_2       = $random(seed);
    repeat (RST_CYC) @(negedge clk);
    sys_rst = 1'b0;
    @(negedge clk);
    assert (cmd_ready && !op_done && !rd_data_valid)
    else report_failure("reset state wrong: cmd_ready low or op_done/rd_data_valid high");

    load_coeffs();
    run_op(make_cmd({SRC_CB, DIR_POS}, 1'b0, 0, 0, 8));
    run_op(make_cmd({SRC_CB, DIR_NEG}, 1'b0, 4, 8, 6));
    run_op(make_cmd({SRC_CB, DIR_NEW}, 1'b1, 2, 0, 4));
    run_op(make_cmd({SRC_CB, DIR_NEW}, 1'b0, 10, 4, 4));
    run_op(make_cmd({SRC_NL_UPD, DIR_POS}, 1'b0, 0, 12, 4));
    // Zero rows over rows that already hold data
    run_op(make_cmd({SRC_CB, DIR_IDLE}, 1'b0, 5, 0, 3));
    run_op(make_cmd({SRC_NL_PRD, DIR_POS}, 1'b0, 7, 3, 2));
    run_held_pair(make_cmd({SRC_CB, DIR_POS}, 1'b0, 8, 6, 5),
                  make_cmd({SRC_CB, DIR_NEG}, 1'b0, 11, 11, 5));
    // Whole temporary buffer once more
    read_rows('0, 1 << ADDR_W);

    $display(">>> PASS");
    $finish;
  end

endmodule

//--- logic/ekf_buf_top.sv
module ekf_buf_top
  import ekf_buf_pkg::*;
(
  input  logic              clk,
  input  logic              sys_rst,
  input  map_cmd_t          cmd,
  input  logic              cmd_valid,
  output logic              cmd_ready,
  input  logic              cb_wr_en,
  input  logic [ADDR_W-1:0] cb_wr_addr,
  input  lane_vec_t         cb_wr_data,
  input  lane_word_t        vt_1,
  input  lane_word_t        vt_2,
  input  logic              rd_en,
  input  logic [ADDR_W-1:0] rd_addr,
  output lane_vec_t         rd_data,
  output logic              rd_data_valid,
  output logic              op_done
);

  logic              cb_rd_en;
  logic [ADDR_W-1:0] cb_rd_addr;
  map_step_t         step;
  map_step_t         step_q;
  lane_vec_t         cb_data;
  logic              cb_data_valid;
  tb_wr_t            tb_wr;
  logic              tb_wr_valid;

  map_sequencer seq_i (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cb_rd_en   (cb_rd_en),
    .cb_rd_addr (cb_rd_addr),
    .step       (step),
    .step_valid ()
  );

  // Coefficient rows, loaded from outside while the sequencer is idle
  lane_ram cb_ram_i (
    .clk      (clk),
    .sys_rst  (sys_rst),
    .wr_en    (cb_wr_en),
    .wr_addr  (cb_wr_addr),
    .wr_data  (cb_wr_data),
    .rd_en    (cb_rd_en),
    .rd_addr  (cb_rd_addr),
    .rd_data  (cb_data),
    .rd_valid (cb_data_valid)
  );

  // Step record matched to the read latency, the RAM supplies its valid
  always_ff @(posedge clk) begin
    step_q <= step;
  end

  dina_map map_i (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .step        (step_q),
    .step_valid  (cb_data_valid),
    .cb_data     (cb_data),
    .vt_1        (vt_1),
    .vt_2        (vt_2),
    .tb_wr       (tb_wr),
    .tb_wr_valid (tb_wr_valid),
    .op_done     (op_done)
  );

  // Temporary rows, read back by the external port
  lane_ram tb_ram_i (
    .clk      (clk),
    .sys_rst  (sys_rst),
    .wr_en    (tb_wr_valid),
    .wr_addr  (tb_wr.addr),
    .wr_data  (tb_wr.data),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rd_valid (rd_data_valid)
  );

endmodule

//--- map/dina_map.sv
module dina_map
  import ekf_buf_pkg::*;
(
  input  logic       clk,
  input  logic       sys_rst,
  input  map_step_t  step,
  input  logic       step_valid,
  input  lane_vec_t  cb_data,
  input  lane_word_t vt_1,
  input  lane_word_t vt_2,
  output tb_wr_t     tb_wr,
  output logic       tb_wr_valid,
  output logic       op_done
);

  logic [2:0] src;
  logic [1:0] dir;
  lane_vec_t  row_d;

  assign src = step.sel[SEL_W-1:2];
  assign dir = step.sel[1:0];

  // Next temporary-buffer row
  always_comb begin
    row_d = '0;
    case (src)
      SRC_CB: begin
        case (dir)
          DIR_POS: begin
            row_d = cb_data;
          end
          DIR_NEG: begin
            // Lane i takes lane LANES-1-i
            for (int i = 0; i < LANES; i++) begin
              row_d[i] = cb_data[LANES-1-i];
            end
          end
          DIR_NEW: begin
            // Lower input half lands in the half picked by l_k_0
            for (int h = 0; h < LANES / 2; h++) begin
              if (step.l_k_0) begin
                row_d[h] = cb_data[h];
              end else begin
                row_d[h + LANES / 2] = cb_data[h];
              end
            end
          end
          default: begin
            row_d = '0;
          end
        endcase
      end
      SRC_NL_UPD: begin
        // Update results go to lane 0 of the first two steps only
        case (step.seq_cnt)
          SEQ_W'(1): row_d[0] = vt_1;
          SEQ_W'(2): row_d[0] = vt_2;
          default:   row_d    = '0;
        endcase
      end
      SRC_NL_PRD, SRC_NL_NEW: begin
        // Predict and new-state units are not part of this slice
        row_d = '0;
      end
      default: begin
        row_d = '0;
      end
    endcase
  end

  // Output register feeds the temporary memory write port directly
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      tb_wr <= '0;
    end else if (step_valid) begin
      tb_wr.addr <= step.tb_addr;
      tb_wr.data <= row_d;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      tb_wr_valid <= 1'b0;
      op_done     <= 1'b0;
    end else begin
      tb_wr_valid <= step_valid;
      op_done     <= step_valid && step.last;
    end
  end

  // Completion marks the last write, and the sequencer drain leaves a gap after it
  a_done_with_write: assert property (
    @(posedge clk) disable iff (sys_rst)
    op_done |-> tb_wr_valid ##1 !tb_wr_valid
  ) else $error("op_done not aligned with the final write");

endmodule

//--- map/map_sequencer.sv
module map_sequencer
  import ekf_buf_pkg::*;
(
  input  logic              clk,
  input  logic              sys_rst,
  input  map_cmd_t          cmd,
  input  logic              cmd_valid,
  output logic              cmd_ready,
  output logic              cb_rd_en,
  output logic [ADDR_W-1:0] cb_rd_addr,
  output map_step_t         step,
  output logic              step_valid
);

  // Drain keeps the port busy until the last row has been written
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_DRAIN
  } seq_state_t;

  seq_state_t       state;
  map_cmd_t         cmd_q;
  logic [LEN_W-1:0] step_cnt;
  logic             last_step;
  logic             cmd_fire;

  assign cmd_ready = (state == ST_IDLE);
  assign cmd_fire  = cmd_valid && cmd_ready;

  // Final step of the latched command
  assign last_step = (step_cnt == cmd_q.len - LEN_W'(1));

  // Command is only sampled on transfer
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      cmd_q <= cmd;
    end
  end

  // Step counter doubles as the drain counter
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state    <= ST_IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmd_fire) begin
            state    <= ST_ISSUE;
            step_cnt <= '0;
          end
        end
        ST_ISSUE: begin
          if (last_step) begin
            state    <= ST_DRAIN;
            step_cnt <= '0;
          end else begin
            step_cnt <= step_cnt + LEN_W'(1);
          end
        end
        ST_DRAIN: begin
          // Wait out the alignment and mapper stages
          if (step_cnt == LEN_W'(PIPE_DEPTH - 1)) begin
            state <= ST_IDLE;
          end else begin
            step_cnt <= step_cnt + LEN_W'(1);
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // One coefficient read per issued step
  assign step_valid = (state == ST_ISSUE);
  assign cb_rd_en   = step_valid;
  assign cb_rd_addr = cmd_q.cb_base + step_cnt[ADDR_W-1:0];

  // Step record travels alongside the read
  assign step.sel     = cmd_q.sel;
  assign step.l_k_0   = cmd_q.l_k_0;
  assign step.seq_cnt = SEQ_W'(step_cnt) + SEQ_W'(1);
  assign step.tb_addr = cmd_q.tb_base + step_cnt[ADDR_W-1:0];
  assign step.last    = last_step;

  a_step_busy: assert property (
    @(posedge clk) disable iff (sys_rst)
    step_valid |-> (state != ST_IDLE)
  ) else $error("step issued while sequencer idle");

  // No new command may slip in while steps are going out
  a_no_ready_in_step: assert property (
    @(posedge clk) disable iff (sys_rst)
    step_valid |-> !cmd_ready
  ) else $error("cmd_ready high during an issued step");

endmodule

//--- logic/lane_ram.sv
module lane_ram
  import ekf_buf_pkg::*;
(
  input  logic              clk,
  input  logic              sys_rst,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  lane_vec_t         wr_data,
  input  logic              rd_en,
  input  logic [ADDR_W-1:0] rd_addr,
  output lane_vec_t         rd_data,
  output logic              rd_valid
);

  // One lane vector per row
  lane_vec_t mem [1 << ADDR_W];

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, a same-row write in this cycle is not yet visible
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // Read data qualifier, one cycle after rd_en
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

  // Enabled accesses need clean addresses from whoever drives the port
  a_wr_addr_known: assert property (
    @(posedge clk) disable iff (sys_rst)
    wr_en |-> !$isunknown(wr_addr)
  ) else $error("lane_ram write address has unknown bits");

  a_rd_addr_known: assert property (
    @(posedge clk) disable iff (sys_rst)
    rd_en |-> !$isunknown(rd_addr)
  ) else $error("lane_ram read address has unknown bits");

endmodule

//--- common/ekf_buf_pkg.sv
package ekf_buf_pkg;

  // Lane geometry of one buffer row
  localparam int LANES  = 4;
  localparam int WORD_W = 32;

  // Both memories hold 16 rows
  localparam int ADDR_W = 4;

  // Step count of one operation, 1 to 16
  localparam int LEN_W = 5;
  localparam int SEQ_W = 5;

  // Map select, upper three bits pick the source, lower two the direction
  localparam int SEL_W = 5;

  // Register stages between an issued step and its temporary-buffer write
  localparam int PIPE_DEPTH = 2;

  localparam logic [2:0] SRC_CB     = 3'b100;
  localparam logic [2:0] SRC_NL_PRD = 3'b101;
  localparam logic [2:0] SRC_NL_NEW = 3'b110;
  localparam logic [2:0] SRC_NL_UPD = 3'b111;

  localparam logic [1:0] DIR_IDLE = 2'b00;
  localparam logic [1:0] DIR_POS  = 2'b01;
  localparam logic [1:0] DIR_NEG  = 2'b10;
  localparam logic [1:0] DIR_NEW  = 2'b11;

  typedef logic signed [WORD_W-1:0] lane_word_t;

  // Lane 0 sits in the low bits
  typedef lane_word_t [LANES-1:0] lane_vec_t;

  typedef struct packed {
    logic [SEL_W-1:0]  sel;
    logic              l_k_0;
    logic [ADDR_W-1:0] cb_base;
    logic [ADDR_W-1:0] tb_base;
    logic [LEN_W-1:0]  len;
  } map_cmd_t;

  typedef struct packed {
    logic [SEL_W-1:0]  sel;
    logic              l_k_0;
    // Step number counted from 1
    logic [SEQ_W-1:0]  seq_cnt;
    logic [ADDR_W-1:0] tb_addr;
    logic              last;
  } map_step_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    lane_vec_t         data;
  } tb_wr_t;

endpackage
